// ==== cart_bridge.f ====
logic/cart_pkg.sv
logic/cart_regs.sv
logic/bus_decode.sv
logic/bank_map.sv
logic/cart_mem.sv
logic/cart_top.sv
sim/tb_cart_top.sv

// ==== logic/bank_map.sv ====
`timescale 1ns/100ps

module bank_map #(
    parameter int MEM_ADDR_BITS = cart_pkg::MEM_ADDR_BITS
) (
    input  cart_pkg::rd_req_t   req,
    input  cart_pkg::mem_addr_t prg_offset,
    input  cart_pkg::mem_addr_t chr_offset,
    output cart_pkg::mem_rd_t   rd
);

    localparam int CPU_PAD = MEM_ADDR_BITS - cart_pkg::CPU_ADDR_BITS;
    localparam int CHR_PAD = MEM_ADDR_BITS - cart_pkg::CHR_ADDR_BITS;

    logic [MEM_ADDR_BITS-1:0] prg_base;
    logic [MEM_ADDR_BITS-1:0] chr_base;
    logic [MEM_ADDR_BITS-1:0] prg_bank;
    logic [MEM_ADDR_BITS-1:0] chr_bank;
    logic [MEM_ADDR_BITS-1:0] prg_map;
    logic [MEM_ADDR_BITS-1:0] chr_map;

    // Bus addresses zero-extended to memory width
    assign prg_base = {{CPU_PAD{1'b0}}, req.cpu_addr};
    assign chr_base = {{CHR_PAD{1'b0}}, req.ppu_low_addr};

    assign prg_bank = MEM_ADDR_BITS'(prg_offset);
    assign chr_bank = MEM_ADDR_BITS'(chr_offset);

    // Offsets are aligned to the region size, so OR acts as an add
    assign prg_map = prg_base | prg_bank;
    assign chr_map = chr_base | chr_bank;

    always_comb begin
        rd.prg_addr = cart_pkg::mem_addr_t'(prg_map);
        rd.chr_addr = cart_pkg::mem_addr_t'(chr_map);
        rd.prg_rd   = req.prg_rd;
        rd.chr_rd   = req.chr_rd;
    end

endmodule

// ==== logic/bus_decode.sv ====
`timescale 1ns/100ps

module bus_decode (
    input  logic               M2,
    input  logic               rst_n,
    input  cart_pkg::cpu_bus_t cpu,
    input  cart_pkg::ppu_bus_t ppu,
    input  logic               load_state,
    output cart_pkg::rd_req_t  req,
    output logic               ciram_ce,
    output logic               ciram_a10,
    output logic               loading
);

    logic [1:0] load_sync;    // Load state crossing from the host side

    always_ff @(posedge M2) begin
        if (!rst_n)
            load_sync <= 2'b00;
        else
            load_sync <= {load_sync[0], load_state};
    end

    assign loading = load_sync[1];

    // CIRAM /CE is active low, so CIRAM is off in pattern space
    assign ciram_ce  = !ppu.addr[13];
    // Mirroring taken straight from A10
    assign ciram_a10 = ppu.addr[10];

    always_comb begin
        // PRG read: ROM select low, read cycle, second half of M2
        req.prg_rd = !loading && !cpu.rom_ce && cpu.rw && cpu.m2_high;

        // CHR read only in the pattern tables
        req.chr_rd = !loading && ciram_ce && !ppu.rd_n;

        req.cpu_addr     = cpu.addr;
        req.ppu_low_addr = ppu.addr[cart_pkg::CHR_ADDR_BITS-1:0];
    end

    // Two cycles after load_state rises, the slot is quiet
    reads_blocked_while_loading: assert property (
        @(posedge M2) disable iff (!rst_n)
        $past(rst_n) && $past(rst_n, 2) && $past(load_state, 2)
            |-> !(req.prg_rd || req.chr_rd)
    ) else $error("Read request issued during cartridge load");

endmodule

// ==== logic/cart_mem.sv ====
`timescale 1ns/100ps

module cart_mem #(
    parameter int MEM_ADDR_BITS = cart_pkg::MEM_ADDR_BITS
) (
    input  logic                M2,
    input  logic                rst_n,
    input  cart_pkg::mem_rd_t   rd,
    input  cart_pkg::load_wr_t  wr,
    output cart_pkg::byte_t     cpu_data,
    output logic                cpu_dir,
    output cart_pkg::byte_t     ppu_data,
    output logic                ppu_dir
);

    localparam int DEPTH = 2 ** MEM_ADDR_BITS;

    cart_pkg::byte_t          mem [DEPTH];   // Stands in for the SDRAM
    logic [MEM_ADDR_BITS-1:0] prg_idx;
    logic [MEM_ADDR_BITS-1:0] chr_idx;
    logic [MEM_ADDR_BITS-1:0] wr_idx;

    assign prg_idx = MEM_ADDR_BITS'(rd.prg_addr);
    assign chr_idx = MEM_ADDR_BITS'(rd.chr_addr);
    assign wr_idx  = MEM_ADDR_BITS'(wr.addr);

    // Load port from the host
    always_ff @(posedge M2) begin
        if (wr.we)
            mem[wr_idx] <= wr.data;
    end

    // Read ports see the array before this edge's write
    always_ff @(posedge M2) begin
        if (rd.prg_rd)
            cpu_data <= mem[prg_idx];
        if (rd.chr_rd)
            ppu_data <= mem[chr_idx];
    end

    always_ff @(posedge M2) begin
        if (!rst_n) begin
            cpu_dir <= 1'b0;
            ppu_dir <= 1'b0;
        end else begin
            cpu_dir <= rd.prg_rd;     // Drive enable tracks its data
            ppu_dir <= rd.chr_rd;
        end
    end

    // Offsets and load address must fit the array
    wr_addr_in_range: assert property (
        @(posedge M2) disable iff (!rst_n)
        wr.we |-> (wr.addr >> MEM_ADDR_BITS) == '0
    ) else $error("Load write beyond cart memory");

    rd_addr_in_range: assert property (
        @(posedge M2) disable iff (!rst_n)
        (rd.prg_rd |-> (rd.prg_addr >> MEM_ADDR_BITS) == '0) and
        (rd.chr_rd |-> (rd.chr_addr >> MEM_ADDR_BITS) == '0)
    ) else $error("Read address beyond cart memory");

endmodule

// ==== logic/cart_pkg.sv ====
package cart_pkg;

    // Cartridge slot bus widths
    localparam int CPU_ADDR_BITS = 15;
    localparam int PPU_ADDR_BITS = 14;
    localparam int CHR_ADDR_BITS = 13;     // Pattern tables only, $0000-$1FFF
    localparam int MEM_ADDR_BITS = 16;

    typedef logic [MEM_ADDR_BITS-1:0] mem_addr_t;
    typedef logic [CPU_ADDR_BITS-1:0] cpu_addr_t;
    typedef logic [PPU_ADDR_BITS-1:0] ppu_addr_t;
    typedef logic [7:0]               byte_t;

    typedef logic [4:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // CPU side of the slot, sampled on M2
    typedef struct packed {
        cpu_addr_t addr;
        logic      rw;         // High for a read
        logic      rom_ce;     // Active low, $8000-$FFFF
        logic      m2_high;    // M2 phase seen as a level
    } cpu_bus_t;

    typedef struct packed {
        ppu_addr_t addr;
        logic      rd_n;
    } ppu_bus_t;

    // Qualified reads leaving the decoder
    typedef struct packed {
        logic                     prg_rd;
        logic                     chr_rd;
        cpu_addr_t                cpu_addr;
        logic [CHR_ADDR_BITS-1:0] ppu_low_addr;
    } rd_req_t;

    typedef struct packed {
        mem_addr_t prg_addr;
        mem_addr_t chr_addr;
        logic      prg_rd;
        logic      chr_rd;
    } mem_rd_t;

    typedef struct packed {
        logic      we;
        mem_addr_t addr;
        byte_t     data;
    } load_wr_t;

    // APB register map
    localparam apb_addr_t REG_PRG_OFFSET = 5'h00;
    localparam apb_addr_t REG_CHR_OFFSET = 5'h04;
    localparam apb_addr_t REG_CONTROL    = 5'h08;
    localparam apb_addr_t REG_LOAD_ADDR  = 5'h0C;
    localparam apb_addr_t REG_LOAD_DATA  = 5'h10;
    localparam int        CTRL_LOAD_BIT  = 0;

    typedef enum logic [1:0] {IDLE, SETUP, ACCESS} apb_state_t;

endpackage

// ==== logic/cart_regs.sv ====
`timescale 1ns/100ps

module cart_regs (
    input  logic                M2,
    input  logic                rst_n,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  cart_pkg::apb_addr_t paddr,
    input  cart_pkg::apb_data_t pwdata,
    output cart_pkg::apb_data_t prdata,
    output cart_pkg::mem_addr_t prg_offset,
    output cart_pkg::mem_addr_t chr_offset,
    output logic                load_state,
    output cart_pkg::load_wr_t  load_wr
);

    cart_pkg::apb_state_t apb_state;    // Phase of the previous cycle
    cart_pkg::apb_state_t apb_next;
    logic                 wr_en;
    logic                 load_hit;
    cart_pkg::mem_addr_t  load_addr;    // Next byte of the load window
    logic                 wr_we_q;
    cart_pkg::mem_addr_t  wr_addr_q;
    cart_pkg::byte_t      wr_data_q;

    always_comb begin
        if (!psel)
            apb_next = cart_pkg::IDLE;
        else if (!penable)
            apb_next = cart_pkg::SETUP;
        else
            apb_next = cart_pkg::ACCESS;
    end

    // Access cycle must follow a setup cycle
    assign wr_en    = psel && penable && pwrite && (apb_state == cart_pkg::SETUP);
    assign load_hit = wr_en && (paddr == cart_pkg::REG_LOAD_DATA);

    always_ff @(posedge M2) begin
        if (!rst_n) begin
            apb_state  <= cart_pkg::IDLE;
            prg_offset <= '0;
            chr_offset <= '0;
            load_state <= 1'b0;
            load_addr  <= '0;
            wr_we_q    <= 1'b0;
        end else begin
            apb_state <= apb_next;
            wr_we_q   <= load_hit;      // One cycle strobe
            if (wr_en) begin
                case (paddr)
                    cart_pkg::REG_PRG_OFFSET: prg_offset <= cart_pkg::mem_addr_t'(pwdata);
                    cart_pkg::REG_CHR_OFFSET: chr_offset <= cart_pkg::mem_addr_t'(pwdata);
                    cart_pkg::REG_CONTROL:    load_state <= pwdata[cart_pkg::CTRL_LOAD_BIT];
                    cart_pkg::REG_LOAD_ADDR:  load_addr  <= cart_pkg::mem_addr_t'(pwdata);
                    cart_pkg::REG_LOAD_DATA:  load_addr  <= load_addr + 1'b1;
                    default: ;
                endcase
            end
        end
    end

    // Byte and address of the pending memory write
    always_ff @(posedge M2) begin
        if (load_hit) begin
            wr_addr_q <= load_addr;
            wr_data_q <= cart_pkg::byte_t'(pwdata);
        end
    end

    always_comb begin
        load_wr.we   = wr_we_q;
        load_wr.addr = wr_addr_q;
        load_wr.data = wr_data_q;
    end

    always_comb begin
        prdata = '0;
        if (psel && !pwrite) begin
            case (paddr)
                cart_pkg::REG_PRG_OFFSET: prdata = cart_pkg::apb_data_t'(prg_offset);
                cart_pkg::REG_CHR_OFFSET: prdata = cart_pkg::apb_data_t'(chr_offset);
                cart_pkg::REG_CONTROL:    prdata[cart_pkg::CTRL_LOAD_BIT] = load_state;
                cart_pkg::REG_LOAD_ADDR:  prdata = cart_pkg::apb_data_t'(load_addr);
                default:                  prdata = '0;   // Data window reads as zero
            endcase
        end
    end

    // APB: enable is only raised after a cycle with the slave selected
    penable_after_psel: assert property (
        @(posedge M2) disable iff (!rst_n)
        $rose(penable) |-> $past(psel)
    ) else $error("penable rose without psel in the setup cycle");

endmodule

// ==== logic/cart_top.sv ====
`timescale 1ns/100ps

module cart_top #(
    parameter int MEM_ADDR_BITS = cart_pkg::MEM_ADDR_BITS
) (
    input  logic                M2,
    input  logic                rst_n,

    // Host side
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  cart_pkg::apb_addr_t paddr,
    input  cart_pkg::apb_data_t pwdata,
    output cart_pkg::apb_data_t prdata,

    // Console slot
    input  cart_pkg::cpu_bus_t  cpu,
    input  cart_pkg::ppu_bus_t  ppu,
    output cart_pkg::byte_t     cpu_data,
    output logic                cpu_dir,
    output cart_pkg::byte_t     ppu_data,
    output logic                ppu_dir,
    output logic                ciram_ce,
    output logic                ciram_a10
);

    cart_pkg::mem_addr_t prg_offset;
    cart_pkg::mem_addr_t chr_offset;
    logic                load_state;
    cart_pkg::load_wr_t  load_wr;
    cart_pkg::rd_req_t   req;
    cart_pkg::mem_rd_t   rd;

    cart_regs u_regs (
        .M2         (M2),
        .rst_n      (rst_n),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .prg_offset (prg_offset),
        .chr_offset (chr_offset),
        .load_state (load_state),
        .load_wr    (load_wr)
    );

    bus_decode u_decode (
        .M2         (M2),
        .rst_n      (rst_n),
        .cpu        (cpu),
        .ppu        (ppu),
        .load_state (load_state),
        .req        (req),
        .ciram_ce   (ciram_ce),
        .ciram_a10  (ciram_a10),
        .loading    ()
    );

    bank_map #(
        .MEM_ADDR_BITS (MEM_ADDR_BITS)
    ) u_map (
        .req        (req),
        .prg_offset (prg_offset),
        .chr_offset (chr_offset),
        .rd         (rd)
    );

    cart_mem #(
        .MEM_ADDR_BITS (MEM_ADDR_BITS)
    ) u_mem (
        .M2         (M2),
        .rst_n      (rst_n),
        .rd         (rd),
        .wr         (load_wr),
        .cpu_data   (cpu_data),
        .cpu_dir    (cpu_dir),
        .ppu_data   (ppu_data),
        .ppu_dir    (ppu_dir)
    );

endmodule

// ==== run.sh ====
#!/bin/sh
# Build the cart bridge testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_cart_top \
    -f cart_bridge.f -o sim_cart \
    && ./obj_dir/sim_cart | tee /dev/stderr | grep -x '>>> PASS' > /dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// ==== sim/tb_cart_top.sv ====
`timescale 1ns/100ps

module tb_cart_top;

    localparam int MEM_ADDR_BITS = cart_pkg::MEM_ADDR_BITS;
    localparam int LOAD_COUNT    = 32;
    localparam int CYCLE_LIMIT   = 4000;   // Full run is a few hundred cycles

    logic                M2;
    logic                rst_n;
    logic                psel;
    logic                penable;
    logic                pwrite;
    cart_pkg::apb_addr_t paddr;
    cart_pkg::apb_data_t pwdata;
    cart_pkg::apb_data_t prdata;
    cart_pkg::cpu_bus_t  cpu;
    cart_pkg::ppu_bus_t  ppu;
    cart_pkg::byte_t     cpu_data;
    logic                cpu_dir;
    cart_pkg::byte_t     ppu_data;
    logic                ppu_dir;
    logic                ciram_ce;
    logic                ciram_a10;

    // Host side copy of the registers
    cart_pkg::mem_addr_t prg_off;
    cart_pkg::mem_addr_t chr_off;
    logic                ctrl_load;
    logic [1:0]          load_pipe;    // Loading lags the control bit by 2 cycles
    logic                load_seen;

    cart_pkg::byte_t     ref_mem [2**MEM_ADDR_BITS];
    cart_pkg::mem_addr_t prg_map_addr;
    cart_pkg::mem_addr_t chr_map_addr;
    logic                cpu_qual;
    logic                ppu_qual;
    logic                cpu_qual_q;
    logic                ppu_qual_q;
    cart_pkg::byte_t     exp_cpu_q;
    cart_pkg::byte_t     exp_ppu_q;
    logic                rd_check;
    cart_pkg::apb_data_t exp_prdata;

    int seed;
    int errors;
    int tests_run;
    int tests_failed;
    int test_errs;
    int cycle_count = 0;

    cart_top #(
        .MEM_ADDR_BITS (MEM_ADDR_BITS)
    ) u_dut (
        .M2        (M2),
        .rst_n     (rst_n),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .cpu       (cpu),
        .ppu       (ppu),
        .cpu_data  (cpu_data),
        .cpu_dir   (cpu_dir),
        .ppu_data  (ppu_data),
        .ppu_dir   (ppu_dir),
        .ciram_ce  (ciram_ce),
        .ciram_a10 (ciram_a10)
    );

    initial begin
        M2 = 1'b0;
        forever #4 M2 = ~M2;
    end

    // Expected slot behavior from the bus pins
    assign load_seen    = load_pipe[1];
    assign cpu_qual     = !load_seen && !cpu.rom_ce && cpu.rw && cpu.m2_high;
    assign ppu_qual     = !load_seen && !ppu.addr[13] && !ppu.rd_n;
    assign prg_map_addr = {1'b0, cpu.addr} | prg_off;
    assign chr_map_addr = {3'b000, ppu.addr[12:0]} | chr_off;   // Pattern space is 8 KB

    always @(posedge M2) begin
        if (!rst_n) begin
            load_pipe  <= 2'b00;
            cpu_qual_q <= 1'b0;
            ppu_qual_q <= 1'b0;
        end else begin
            load_pipe  <= {load_pipe[0], ctrl_load};
            cpu_qual_q <= cpu_qual;
            ppu_qual_q <= ppu_qual;
        end
        exp_cpu_q <= ref_mem[prg_map_addr];
        exp_ppu_q <= ref_mem[chr_map_addr];
    end

    always @(posedge M2) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display(">>> FAIL");
            $finish;
        end
    end

    function automatic void record_mismatch(input string sig, input int unsigned expected,
                                            input int unsigned actual);
        errors++;
        $display("Mismatch at %0t: %s expected %0h, actual %0h", $time, sig, expected, actual);
    endfunction

    cpu_dir_check: assert property (@(posedge M2) disable iff (!rst_n)
        cpu_dir == cpu_qual_q)
        else record_mismatch("cpu_dir", 32'($sampled(cpu_qual_q)), 32'($sampled(cpu_dir)));

    ppu_dir_check: assert property (@(posedge M2) disable iff (!rst_n)
        ppu_dir == ppu_qual_q)
        else record_mismatch("ppu_dir", 32'($sampled(ppu_qual_q)), 32'($sampled(ppu_dir)));

    cpu_data_check: assert property (@(posedge M2) disable iff (!rst_n)
        cpu_dir |-> cpu_data == exp_cpu_q)
        else record_mismatch("cpu_data", 32'($sampled(exp_cpu_q)), 32'($sampled(cpu_data)));

    ppu_data_check: assert property (@(posedge M2) disable iff (!rst_n)
        ppu_dir |-> ppu_data == exp_ppu_q)
        else record_mismatch("ppu_data", 32'($sampled(exp_ppu_q)), 32'($sampled(ppu_data)));

    ciram_ce_check: assert property (@(posedge M2) disable iff (!rst_n)
        ciram_ce == !ppu.addr[13])
        else record_mismatch("ciram_ce", 32'(!$sampled(ppu.addr[13])), 32'($sampled(ciram_ce)));

    ciram_a10_check: assert property (@(posedge M2) disable iff (!rst_n)
        ciram_a10 == ppu.addr[10])
        else record_mismatch("ciram_a10", 32'($sampled(ppu.addr[10])), 32'($sampled(ciram_a10)));

    prdata_check: assert property (@(posedge M2) disable iff (!rst_n)
        rd_check |-> prdata == exp_prdata)
        else record_mismatch("prdata", $sampled(exp_prdata), $sampled(prdata));

    task automatic tick();
        @(posedge M2);
        #1;
    endtask

    task automatic apb_write(input cart_pkg::apb_addr_t addr, input cart_pkg::apb_data_t data);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        tick();
        penable = 1'b1;
        tick();                    // Write lands on this edge
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        case (addr)
            cart_pkg::REG_PRG_OFFSET: prg_off = cart_pkg::mem_addr_t'(data);
            cart_pkg::REG_CHR_OFFSET: chr_off = cart_pkg::mem_addr_t'(data);
            cart_pkg::REG_CONTROL:    ctrl_load = data[0];
            default: ;
        endcase
    endtask

    task automatic apb_read(input cart_pkg::apb_addr_t addr, input cart_pkg::apb_data_t expected);
        psel       = 1'b1;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = addr;
        tick();
        penable    = 1'b1;
        rd_check   = 1'b1;
        exp_prdata = expected;
        tick();
        psel       = 1'b0;
        penable    = 1'b0;
        rd_check   = 1'b0;
    endtask

    task automatic load_bytes(input cart_pkg::mem_addr_t base, input int count);
        cart_pkg::mem_addr_t addr;
        cart_pkg::byte_t     value;
        int                  i;
        addr = base;
        apb_write(cart_pkg::REG_LOAD_ADDR, cart_pkg::apb_data_t'(base));
        for (i = 0; i < count; i++) begin
            value = cart_pkg::byte_t'($random(seed));
            ref_mem[addr] = value;
            apb_write(cart_pkg::REG_LOAD_DATA, cart_pkg::apb_data_t'(value));
            addr = addr + 16'd1;
        end
        tick();    // Last byte reaches memory
    endtask

    task automatic drive_cpu(input cart_pkg::cpu_addr_t addr, input logic rw,
                             input logic rom_ce, input logic m2_high);
        cpu.addr    = addr;
        cpu.rw      = rw;
        cpu.rom_ce  = rom_ce;
        cpu.m2_high = m2_high;
    endtask

    task automatic drive_ppu(input cart_pkg::ppu_addr_t addr, input logic rd_n);
        ppu.addr = addr;
        ppu.rd_n = rd_n;
    endtask

    task automatic end_test(input string name);
        repeat (3) tick();    // Last read still in flight
        tests_run++;
        if (errors != test_errs) begin
            tests_failed++;
            $display("Test %0d %s: failed, %0d errors", tests_run, name, errors - test_errs);
        end else begin
            $display("Test %0d %s: ok", tests_run, name);
        end
        test_errs = errors;
    endtask

    initial begin
        int          i;
        logic [31:0] r;
        seed       = 32'h3db0;
        rst_n      = 1'b0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        drive_cpu('0, 1'b1, 1'b1, 1'b0);
        drive_ppu('0, 1'b1);
        prg_off    = '0;
        chr_off    = '0;
        ctrl_load  = 1'b0;
        rd_check   = 1'b0;
        exp_prdata = '0;
        errors     = 0;
        tests_run  = 0;
        tests_failed = 0;
        test_errs  = 0;
        repeat (5) @(posedge M2);
        #1 rst_n = 1'b1;

        tick();
        apb_read(cart_pkg::REG_PRG_OFFSET, 32'h0);
        apb_read(cart_pkg::REG_CHR_OFFSET, 32'h0);
        apb_read(cart_pkg::REG_CONTROL, 32'h0);
        end_test("reset state");

        load_bytes(16'h0000, LOAD_COUNT);
        for (i = 0; i < LOAD_COUNT; i++) begin
            drive_cpu(cart_pkg::cpu_addr_t'(i), 1'b1, 1'b0, 1'b1);
            tick();
        end
        drive_cpu('0, 1'b1, 1'b1, 1'b0);
        end_test("load and cpu read");

        // PRG bank at 32 KB, CHR bank at 40 KB
        apb_write(cart_pkg::REG_PRG_OFFSET, 32'h8000);
        apb_write(cart_pkg::REG_CHR_OFFSET, 32'hA000);
        load_bytes(16'h8000, 16);
        load_bytes(16'hA040, 16);
        for (i = 0; i < 16; i++) begin
            drive_cpu(cart_pkg::cpu_addr_t'(i), 1'b1, 1'b0, 1'b1);
            drive_ppu(cart_pkg::ppu_addr_t'(14'h0040 + i), 1'b0);
            tick();
        end
        drive_cpu('0, 1'b1, 1'b1, 1'b0);
        drive_ppu('0, 1'b1);
        end_test("banked reads");

        drive_cpu(15'h0005, 1'b1, 1'b0, 1'b1);
        drive_ppu(14'h0045, 1'b0);
        apb_write(cart_pkg::REG_CONTROL, 32'h1);
        for (i = 0; i < 6; i++) begin
            drive_cpu(cart_pkg::cpu_addr_t'(i), 1'b1, 1'b0, 1'b1);
            drive_ppu(cart_pkg::ppu_addr_t'(14'h0040 + i), 1'b0);
            tick();
        end
        apb_read(cart_pkg::REG_CONTROL, 32'h1);
        apb_write(cart_pkg::REG_CONTROL, 32'h0);
        for (i = 6; i < 12; i++) begin
            drive_cpu(cart_pkg::cpu_addr_t'(i), 1'b1, 1'b0, 1'b1);
            drive_ppu(cart_pkg::ppu_addr_t'(14'h0040 + i), 1'b0);
            tick();
        end
        drive_cpu('0, 1'b1, 1'b1, 1'b0);
        drive_ppu('0, 1'b1);
        end_test("load blocks reads");

        // Nametable reads only, pattern space left idle
        for (i = 0; i < 16; i++) begin
            r = $random(seed);
            r[13] = i[0];
            drive_ppu(cart_pkg::ppu_addr_t'(r), !r[13]);
            tick();
        end
        drive_ppu('0, 1'b1);
        end_test("ciram select");

        drive_cpu(15'h0003, 1'b1, 1'b0, 1'b0);    // M2 low
        tick();
        drive_cpu(15'h0004, 1'b0, 1'b0, 1'b1);    // Write cycle
        tick();
        drive_cpu(15'h0005, 1'b1, 1'b1, 1'b1);    // ROM not selected
        tick();
        drive_cpu(15'h0006, 1'b1, 1'b0, 1'b1);
        tick();
        for (i = 0; i < 12; i++) begin
            r = $random(seed);
            drive_cpu(cart_pkg::cpu_addr_t'(r[3:0]), r[4], r[5], r[6]);
            tick();
        end
        drive_cpu('0, 1'b1, 1'b1, 1'b0);
        end_test("cpu qualification");

        $display("Summary: %0d tests, %0d failed, %0d check errors",
                 tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule
